//--- tb.f
+incdir+.
axi_pkg.sv
pix_pkg.sv
sync_fifo.sv
fb_pix_reader.sv
fb_ram.sv
fb_pix_top.sv
tb_fb_pix_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_fb_pix_top
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard *.svh)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "all tests passed" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_fb_pix_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "fb_params.svh"

module tb_fb_pix_top
  import axi_pkg::*;
  import pix_pkg::*;
;

  localparam int NUM_ROWS = 5;

  typedef struct {
    int h;
    int v;
    int frames;
    int bp;
  } row_t;

  logic                      clk;
  logic                      rst_n;
  logic [`H_WIDTH-1:0]       h_visible;
  logic [`V_WIDTH-1:0]       v_visible;
  logic                      pix_ready;
  logic                      wr_en;
  logic [`FB_DEPTH_LOG2-1:0] wr_addr;
  axi_data_t                 wr_data;
  logic                      pix_valid;
  rgb_t                      pix_rgb;
  logic [`H_WIDTH-1:0]       pix_x;
  logic [`V_WIDTH-1:0]       pix_y;
  axi_addr_t                 pix_addr;

  row_t        rows [NUM_ROWS];
  int          err_cnt;
  int          check_cnt;
  int          limit_cycles;
  int unsigned seed_draw;

  fb_pix_top i_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_h_visible (h_visible),
    .i_v_visible (v_visible),
    .o_pix_valid (pix_valid),
    .o_pix_rgb   (pix_rgb),
    .o_pix_x     (pix_x),
    .o_pix_y     (pix_y),
    .o_pix_addr  (pix_addr),
    .i_pix_ready (pix_ready),
    .i_wr_en     (wr_en),
    .i_wr_addr   (wr_addr),
    .i_wr_data   (wr_data)
  );

  always #50 clk = ~clk;

  // word k of the frame buffer carries (k*37+5) in its colour bits
  function automatic logic [11:0] colour_of(input int k);
    return 12'(k * 37 + 5);
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    check_cnt++;
    if (exp !== act) begin
      err_cnt++;
      $display("mismatch %s expected %h actual %h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic report_error(input string what);
    err_cnt++;
    $display("error at %0t: %s", $time, what);
  endtask

  // load the buffer, then hold reset for 10 cycles with the new frame size
  task automatic reset_and_load(input row_t row);
    for (int k = 0; k < row.h * row.v; k++) begin
      @(posedge clk);
      wr_en   <= 1'b1;
      wr_addr <= k[`FB_DEPTH_LOG2-1:0];
      wr_data <= axi_data_t'(colour_of(k));
    end
    @(posedge clk);
    wr_en     <= 1'b0;
    rst_n     <= 1'b0;
    pix_ready <= 1'b1;
    @(posedge clk);
    h_visible <= row.h[`H_WIDTH-1:0];
    v_visible <= row.v[`V_WIDTH-1:0];
    repeat (9) begin
      @(posedge clk);
      if (pix_valid !== 1'b0) begin
        report_error("pixel valid is not low during reset");
      end
    end
    rst_n <= 1'b1;
  endtask

  task automatic run_frames(input row_t row, output int pixels);
    int          total;
    int          p;
    int          cycle;
    logic        held;
    logic [31:0] held_rgb;
    logic [31:0] held_x;
    logic [31:0] held_y;
    logic [31:0] held_addr;
    total  = row.h * row.v * row.frames;
    pixels = 0;
    p      = 0;
    cycle  = 0;
    held   = 1'b0;
    while (pixels < total) begin
      @(posedge clk);
      if (cycle < 2 && pix_valid !== 1'b0) begin
        report_error("pixel valid came up right after reset release");
      end
      // a stalled pixel must stay put until it is taken
      if (held) begin
        if (pix_valid !== 1'b1) begin
          report_error("pixel valid dropped while ready was low");
        end
        check_value("o_pix_rgb", held_rgb, 32'(pix_rgb));
        check_value("o_pix_x", held_x, 32'(pix_x));
        check_value("o_pix_y", held_y, 32'(pix_y));
        check_value("o_pix_addr", held_addr, 32'(pix_addr));
      end
      if (pix_valid === 1'b1 && pix_ready === 1'b1) begin
        check_value("o_pix_x", 32'(p % row.h), 32'(pix_x));
        check_value("o_pix_y", 32'(p / row.h), 32'(pix_y));
        check_value("o_pix_addr", 32'(2 * p), 32'(pix_addr));
        check_value("o_pix_rgb", 32'(colour_of(p)), 32'(pix_rgb));
        pixels++;
        p    = (p + 1 == row.h * row.v) ? 0 : p + 1;
        held = 1'b0;
      end else if (pix_valid === 1'b1) begin
        held      = 1'b1;
        held_rgb  = 32'(pix_rgb);
        held_x    = 32'(pix_x);
        held_y    = 32'(pix_y);
        held_addr = 32'(pix_addr);
      end else begin
        held = 1'b0;
      end
      cycle++;
      pix_ready <= (($urandom % 100) >= row.bp);
    end
    pix_ready <= 1'b1;
  endtask

  // ends the run after 20 cycles per pixel plus reset and load time
  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("timeout: the pixel stream did not finish within %0d cycles", limit_cycles);
    $display("tests failed");
    $finish;
  end

  initial begin
    int pixels;
    int errs_before;
    int budget;
    clk       = 1'b0;
    rst_n     = 1'b0;
    h_visible = '0;
    v_visible = '0;
    pix_ready = 1'b1;
    wr_en     = 1'b0;
    wr_addr   = '0;
    wr_data   = '0;
    err_cnt   = 0;
    check_cnt = 0;
    seed_draw = $urandom(32'hcced);

    // h, v, frames, back-pressure percent
    rows[0] = '{4, 3, 1, 0};
    rows[1] = '{4, 3, 3, 0};
    rows[2] = '{8, 4, 2, 50};
    rows[3] = '{1, 1, 4, 0};
    rows[4] = '{16, 2, 2, 60};

    budget = 0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      budget += rows[r].h * rows[r].v * rows[r].frames * 20;
      budget += rows[r].h * rows[r].v + 16;
    end
    limit_cycles = budget;

    for (int r = 0; r < NUM_ROWS; r++) begin
      errs_before = err_cnt;
      reset_and_load(rows[r]);
      run_frames(rows[r], pixels);
      $display("row %0d: %0dx%0d, %0d frames, %0d%% stall: %0d pixels, %0d errors",
               r, rows[r].h, rows[r].v, rows[r].frames, rows[r].bp, pixels,
               err_cnt - errs_before);
    end

    $display("rows %0d, checks %0d, errors %0d", NUM_ROWS, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- fb_pix_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "fb_params.svh"

module fb_pix_top
  import axi_pkg::*;
  import pix_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [`H_WIDTH-1:0]       i_h_visible,
  input  logic [`V_WIDTH-1:0]       i_v_visible,
  output logic                      o_pix_valid,
  output rgb_t                      o_pix_rgb,
  output logic [`H_WIDTH-1:0]       o_pix_x,
  output logic [`V_WIDTH-1:0]       o_pix_y,
  output axi_addr_t                 o_pix_addr,
  input  logic                      i_pix_ready,
  input  logic                      i_wr_en,
  input  logic [`FB_DEPTH_LOG2-1:0] i_wr_addr,
  input  axi_data_t                 i_wr_data
);

  // read address channel
  logic                     arvalid;
  logic [`AXI_ID_WIDTH-1:0] arid;
  axi_addr_t                araddr;
  logic [7:0]               arlen;
  axi_size_t                arsize;
  axi_burst_t               arburst;
  logic                     arready;

  // read data channel
  logic                     rvalid;
  logic [`AXI_ID_WIDTH-1:0] rid;
  axi_data_t                rdata;
  axi_resp_t                rresp;
  logic                     rlast;
  logic                     rready;

  fb_pix_reader i_reader (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_h_visible (i_h_visible),
    .i_v_visible (i_v_visible),
    .o_pix_valid (o_pix_valid),
    .o_pix_rgb   (o_pix_rgb),
    .o_pix_x     (o_pix_x),
    .o_pix_y     (o_pix_y),
    .o_pix_addr  (o_pix_addr),
    .i_pix_ready (i_pix_ready),
    .o_arvalid   (arvalid),
    .o_arid      (arid),
    .o_araddr    (araddr),
    .o_arlen     (arlen),
    .o_arsize    (arsize),
    .o_arburst   (arburst),
    .i_arready   (arready),
    .i_rvalid    (rvalid),
    .i_rid       (rid),
    .i_rdata     (rdata),
    .i_rresp     (rresp),
    .i_rlast     (rlast),
    .o_rready    (rready)
  );

  fb_ram i_ram (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_wr_en   (i_wr_en),
    .i_wr_addr (i_wr_addr),
    .i_wr_data (i_wr_data),
    .i_arvalid (arvalid),
    .i_arid    (arid),
    .i_araddr  (araddr),
    .i_arlen   (arlen),
    .i_arsize  (arsize),
    .i_arburst (arburst),
    .o_arready (arready),
    .o_rvalid  (rvalid),
    .o_rid     (rid),
    .o_rdata   (rdata),
    .o_rresp   (rresp),
    .o_rlast   (rlast),
    .i_rready  (rready)
  );

endmodule

`default_nettype wire

//--- fb_ram.sv
`timescale 1ns/10ps
`default_nettype none

`include "fb_params.svh"

module fb_ram
  import axi_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      i_wr_en,
  input  logic [`FB_DEPTH_LOG2-1:0] i_wr_addr,
  input  axi_data_t                 i_wr_data,
  input  logic                      i_arvalid,
  input  logic [`AXI_ID_WIDTH-1:0]  i_arid,
  input  axi_addr_t                 i_araddr,
  input  logic [7:0]                i_arlen,
  input  axi_size_t                 i_arsize,
  input  axi_burst_t                i_arburst,
  output logic                      o_arready,
  output logic                      o_rvalid,
  output logic [`AXI_ID_WIDTH-1:0]  o_rid,
  output axi_data_t                 o_rdata,
  output axi_resp_t                 o_rresp,
  output logic                      o_rlast,
  input  logic                      i_rready
);

  localparam int DEPTH = 1 << `FB_DEPTH_LOG2;

  axi_data_t mem [DEPTH];

  axi_data_t                 rd_word;
  logic                      rd_pending;
  logic                      ar_accept;
  logic [`FB_DEPTH_LOG2-1:0] rd_index;
  logic                      resp_half_full;
  logic                      resp_empty;

  assign ar_accept = i_arvalid & o_arready;

  // byte address to word index
  assign rd_index = i_araddr[`FB_DEPTH_LOG2:1];

  always_ff @(posedge clk) begin
    if (i_wr_en) begin
      mem[i_wr_addr] <= i_wr_data;
    end
    if (ar_accept) begin
      rd_word <= mem[rd_index];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_pending <= 1'b0;
      o_rid      <= '0;
    end else begin
      rd_pending <= ar_accept;
      // responses return in order, so the last accepted id is the one echoed
      if (ar_accept) begin
        o_rid <= i_arid;
      end
    end
  end

  // response queue absorbs back-pressure from the r channel
  sync_fifo #(
    .T_DATA     (axi_data_t),
    .ADDR_WIDTH (`FIFO_ADDR_WIDTH)
  ) i_resp_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_push      (rd_pending),
    .i_data      (rd_word),
    .i_pop       (o_rvalid & i_rready),
    .o_data      (o_rdata),
    .o_full      (),
    .o_half_full (resp_half_full),
    .o_empty     (resp_empty)
  );

  // stop taking addresses while the queue is half full, leaving room for reads in flight
  assign o_arready = ~resp_half_full;
  assign o_rvalid  = ~resp_empty;
  assign o_rresp   = AXI_RESP_OKAY;
  assign o_rlast   = 1'b1;

  a_r_held: assert property (@(posedge clk) disable iff (!rst_n)
    o_rvalid && !i_rready |=> o_rvalid && $stable(o_rdata));

  // only single-beat full-width incrementing reads are served
  a_single_beat: assert property (@(posedge clk) disable iff (!rst_n)
    i_arvalid |-> i_arlen == 8'd0 && i_arsize == AXI_SIZE_FULL && i_arburst == AXI_BURST_INCR);

endmodule

`default_nettype wire

//--- fb_pix_reader.sv
`timescale 1ns/10ps
`default_nettype none

`include "fb_params.svh"

module fb_pix_reader
  import axi_pkg::*;
  import pix_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic [`H_WIDTH-1:0]      i_h_visible,
  input  logic [`V_WIDTH-1:0]      i_v_visible,
  output logic                     o_pix_valid,
  output rgb_t                     o_pix_rgb,
  output logic [`H_WIDTH-1:0]      o_pix_x,
  output logic [`V_WIDTH-1:0]      o_pix_y,
  output axi_addr_t                o_pix_addr,
  input  logic                     i_pix_ready,
  output logic                     o_arvalid,
  output logic [`AXI_ID_WIDTH-1:0] o_arid,
  output axi_addr_t                o_araddr,
  output logic [7:0]               o_arlen,
  output axi_size_t                o_arsize,
  output axi_burst_t               o_arburst,
  input  logic                     i_arready,
  input  logic                     i_rvalid,
  input  logic [`AXI_ID_WIDTH-1:0] i_rid,
  input  axi_data_t                i_rdata,
  input  axi_resp_t                i_rresp,
  input  logic                     i_rlast,
  output logic                     o_rready
);

  localparam int PIX_WIDTH = 3 * `COLOR_WIDTH;
  localparam axi_addr_t ADDR_STEP = axi_addr_t'(1 << AXI_SIZE_FULL);

  logic [`H_WIDTH-1:0] x;
  logic [`H_WIDTH-1:0] x_next;
  logic [`V_WIDTH-1:0] y;
  logic [`V_WIDTH-1:0] y_next;
  axi_addr_t           araddr_next;
  logic                arvalid_next;
  logic                ar_accept;
  logic                tag_half_full;
  logic                tag_empty;
  pix_tag_t            tag_in;
  pix_tag_t            tag_out;

  // single-beat full-width reads with one fixed id
  assign o_arid    = '0;
  assign o_arlen   = 8'd0;
  assign o_arsize  = AXI_SIZE_FULL;
  assign o_arburst = AXI_BURST_INCR;

  assign ar_accept = o_arvalid & i_arready;

  // r channel goes straight through to the pixel stream
  assign o_pix_valid = i_rvalid;
  assign o_rready    = i_pix_ready;
  assign o_pix_rgb   = rgb_t'(i_rdata[PIX_WIDTH-1:0]);

  always_comb begin
    // hold a pending request, raise a new one while the tag FIFO has room
    arvalid_next = o_arvalid & ~i_arready;
    if ((!o_arvalid || i_arready) && !tag_half_full) begin
      arvalid_next = 1'b1;
    end
  end

  always_comb begin
    x_next      = x;
    y_next      = y;
    araddr_next = o_araddr;
    if (ar_accept) begin
      araddr_next = o_araddr + ADDR_STEP;
      if (x < i_h_visible - 1'b1) begin
        x_next = x + 1'b1;
      end else begin
        x_next = '0;
        if (y < i_v_visible - 1'b1) begin
          y_next = y + 1'b1;
        end else begin
          // end of frame
          y_next      = '0;
          araddr_next = '0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      x         <= '0;
      y         <= '0;
      o_araddr  <= '0;
      o_arvalid <= 1'b0;
    end else begin
      x         <= x_next;
      y         <= y_next;
      o_araddr  <= araddr_next;
      o_arvalid <= arvalid_next;
    end
  end

  always_comb begin
    tag_in.x    = x;
    tag_in.y    = y;
    tag_in.addr = o_araddr;
  end

  sync_fifo #(
    .T_DATA     (pix_tag_t),
    .ADDR_WIDTH (`FIFO_ADDR_WIDTH)
  ) i_tag_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_push      (ar_accept),
    .i_data      (tag_in),
    .i_pop       (i_rvalid & i_pix_ready),
    .o_data      (tag_out),
    .o_full      (),
    .o_half_full (tag_half_full),
    .o_empty     (tag_empty)
  );

  assign o_pix_x    = tag_out.x;
  assign o_pix_y    = tag_out.y;
  assign o_pix_addr = tag_out.addr;

  a_ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
    o_arvalid && !i_arready |=> o_arvalid && $stable(o_araddr));

  // every returning beat belongs to a tag pushed on an earlier accept
  a_r_matches_tag: assert property (@(posedge clk) disable iff (!rst_n)
    i_rvalid |-> !tag_empty && i_rlast && i_rresp == AXI_RESP_OKAY && i_rid == o_arid);

endmodule

`default_nettype wire

//--- sync_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module sync_fifo #(
  parameter type T_DATA = logic [7:0],
  parameter int ADDR_WIDTH = 4
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  i_push,
  input  T_DATA i_data,
  input  logic  i_pop,
  output T_DATA o_data,
  output logic  o_full,
  output logic  o_half_full,
  output logic  o_empty
);

  localparam int DEPTH = 1 << ADDR_WIDTH;

  T_DATA mem [DEPTH];

  logic [ADDR_WIDTH-1:0] wr_ptr;
  logic [ADDR_WIDTH-1:0] rd_ptr;
  // one extra bit so that a full buffer is told apart from an empty one
  logic [ADDR_WIDTH:0]   count;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (i_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (i_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({i_push, i_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (i_push) begin
      mem[wr_ptr] <= i_data;
    end
  end

  // oldest entry is always visible
  assign o_data      = mem[rd_ptr];
  assign o_full      = count[ADDR_WIDTH];
  assign o_half_full = count[ADDR_WIDTH] | count[ADDR_WIDTH-1];
  assign o_empty     = (count == '0);

  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) i_push |-> !o_full);
  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) i_pop |-> !o_empty);

endmodule

`default_nettype wire

//--- pix_pkg.sv
`default_nettype none

`include "fb_params.svh"

package pix_pkg;

  import axi_pkg::*;

  // red in the top bits, blue in the bottom bits
  typedef struct packed {
    logic [`COLOR_WIDTH-1:0] red;
    logic [`COLOR_WIDTH-1:0] green;
    logic [`COLOR_WIDTH-1:0] blue;
  } rgb_t;

  // coordinates of one outstanding read, kept until its data returns
  typedef struct packed {
    logic [`H_WIDTH-1:0] x;
    logic [`V_WIDTH-1:0] y;
    axi_addr_t           addr;
  } pix_tag_t;

endpackage

`default_nettype wire

//--- axi_pkg.sv
`default_nettype none

`include "fb_params.svh"

package axi_pkg;

  typedef logic [1:0] axi_burst_t;
  typedef logic [2:0] axi_size_t;
  typedef logic [1:0] axi_resp_t;

  typedef logic [`AXI_ADDR_WIDTH-1:0] axi_addr_t;
  typedef logic [`AXI_DATA_WIDTH-1:0] axi_data_t;

  localparam axi_burst_t AXI_BURST_INCR = 2'b01;
  localparam axi_resp_t AXI_RESP_OKAY = 2'b00;

  // size code of a beat that fills the whole data bus
  localparam axi_size_t AXI_SIZE_FULL = axi_size_t'($clog2(`AXI_DATA_WIDTH / 8));

endpackage

`default_nettype wire

//--- fb_params.svh
`ifndef FB_PARAMS_SVH
`define FB_PARAMS_SVH

// raster counter widths
`define H_WIDTH 12
`define V_WIDTH 12

// bits per colour channel, three channels per pixel
`define COLOR_WIDTH 4

// read channel widths
`define AXI_ADDR_WIDTH 16
`define AXI_DATA_WIDTH 16
`define AXI_ID_WIDTH 4

// log2 of the depth of the tag FIFO and the response FIFO
`define FIFO_ADDR_WIDTH 4

// log2 of the number of frame buffer words
`define FB_DEPTH_LOG2 10

`endif
